//--- build.f
+incdir+.
vdec_pkg.sv
vdec_mport_fifo.sv
vdec_decode_unit.sv
vdec_decode_ctrl.sv
vdec_decode.sv
vdec_top.sv
tb_clkgen.sv
tb_vdec.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_vdec
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SOURCES   := $(wildcard *.sv *.svh)
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)

# exit status of the simulator is the test result
run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

//--- tb_vdec.sv
`timescale 1ns/1ps

module tb_vdec;

  localparam int NUM_ENTRIES    = 14;
  // run limit scales with the table
  localparam int TIMEOUT_CYCLES = 40 * NUM_ENTRIES + 100;

  logic                clk;
  logic                rst;
  logic                inst_push;
  vdec_pkg::inst_pkg_t inst_data;
  logic                uop_pop;
  logic                cq_full;
  vdec_pkg::uop_t      uop_data;
  logic                uop_empty;

  // stimulus table
  logic [31:0]    tbl_inst  [NUM_ENTRIES];
  logic [31:0]    tbl_rs1   [NUM_ENTRIES];
  logic [1:0]     tbl_lmul  [NUM_ENTRIES];
  int             tbl_count [NUM_ENTRIES];
  vdec_pkg::uop_t exp_q [$];
  logic [7:0]     lfsr_state;
  int             cycle_count;
  int             total_uops;
  int             received;
  logic           saw_full;
  logic           all_sent;

  tb_clkgen #(.PERIOD_NS(8.0)) u_clkgen (.clk(clk));

  vdec_top vdec_top_inst (
    .clk(clk), .rst(rst), .inst_push(inst_push), .inst_data(inst_data),
    .uop_pop(uop_pop), .cq_full(cq_full), .uop_data(uop_data), .uop_empty(uop_empty)
  );

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("CHECKS FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // galois form, taps for x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_step(input logic [7:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 8'hb8;
    end
    return s >> 1;
  endfunction

  // vm is always 1 here
  function automatic logic [31:0] encode_inst(input logic [5:0] f6, input logic [4:0] vs2,
                                              input logic [4:0] f1, input logic [2:0] f3,
                                              input logic [4:0] vd, input logic [6:0] opc);
    return {f6, 1'b1, vs2, f1, f3, vd, opc};
  endfunction

  task automatic set_entry(input int e, input logic [31:0] inst, input logic [31:0] rs1,
                           input logic [1:0] lmul, input int count);
    tbl_inst[e]  = inst;
    tbl_rs1[e]   = rs1;
    tbl_lmul[e]  = lmul;
    tbl_count[e] = count;
  endtask

  task automatic load_table();
    // vadd/vsub in all three forms and all lmul codes
    set_entry(0, encode_inst(vdec_pkg::F6_VADD, 5'd4, 5'd6, vdec_pkg::F3_OPIVV, 5'd2,
              vdec_pkg::OPC_VEC), 32'h0, 2'd0, 1);
    set_entry(1, encode_inst(vdec_pkg::F6_VSUB, 5'd10, 5'd12, vdec_pkg::F3_OPIVV, 5'd8,
              vdec_pkg::OPC_VEC), 32'h0, 2'd1, 2);
    set_entry(2, encode_inst(vdec_pkg::F6_VADD, 5'd20, 5'd5, vdec_pkg::F3_OPIVX, 5'd16,
              vdec_pkg::OPC_VEC), 32'h12345678, 2'd2, 4);
    // scalar opcode, dropped
    set_entry(3, encode_inst(vdec_pkg::F6_VADD, 5'd1, 5'd2, 3'b000, 5'd3, 7'b0110011),
              32'h0, 2'd0, 0);
    // simm5 of -5
    set_entry(4, encode_inst(vdec_pkg::F6_VSUB, 5'd8, 5'h1b, vdec_pkg::F3_OPIVI, 5'd0,
              vdec_pkg::OPC_VEC), 32'h0, 2'd3, 8);
    // whole register moves, imm5 is nr-1
    set_entry(5, encode_inst(vdec_pkg::F6_VMVNR, 5'd3, 5'd0, vdec_pkg::F3_OPIVI, 5'd1,
              vdec_pkg::OPC_VEC), 32'h0, 2'd0, 1);
    set_entry(6, encode_inst(vdec_pkg::F6_VMVNR, 5'd4, 5'd1, vdec_pkg::F3_OPIVI, 5'd6,
              vdec_pkg::OPC_VEC), 32'h0, 2'd3, 2);
    // OPMVV funct3 is outside the subset
    set_entry(7, encode_inst(vdec_pkg::F6_VADD, 5'd2, 5'd3, 3'b010, 5'd4,
              vdec_pkg::OPC_VEC), 32'h0, 2'd1, 0);
    set_entry(8, encode_inst(vdec_pkg::F6_VMVNR, 5'd8, 5'd3, vdec_pkg::F3_OPIVI, 5'd12,
              vdec_pkg::OPC_VEC), 32'h0, 2'd0, 4);
    set_entry(9, encode_inst(vdec_pkg::F6_VMVNR, 5'd16, 5'd7, vdec_pkg::F3_OPIVI, 5'd24,
              vdec_pkg::OPC_VEC), 32'h0, 2'd0, 8);
    set_entry(10, encode_inst(vdec_pkg::F6_VADD, 5'd6, 5'd7, vdec_pkg::F3_OPIVI, 5'd4,
              vdec_pkg::OPC_VEC), 32'h0, 2'd1, 2);
    // nr of 3 is not a legal group size
    set_entry(11, encode_inst(vdec_pkg::F6_VMVNR, 5'd2, 5'd2, vdec_pkg::F3_OPIVI, 5'd5,
              vdec_pkg::OPC_VEC), 32'h0, 2'd0, 0);
    set_entry(12, encode_inst(vdec_pkg::F6_VSUB, 5'd16, 5'd9, vdec_pkg::F3_OPIVX, 5'd8,
              vdec_pkg::OPC_VEC), 32'hdeadbeef, 2'd3, 8);
    set_entry(13, encode_inst(vdec_pkg::F6_VADD, 5'd0, 5'd20, vdec_pkg::F3_OPIVV, 5'd28,
              vdec_pkg::OPC_VEC), 32'h0, 2'd2, 4);
  endtask

  // reference split of one table entry into its expected uops
  task automatic expand_entry(input int e);
    logic [31:0]    w;
    logic [5:0]     f6;
    logic [4:0]     vs2;
    logic [4:0]     f1;
    logic [2:0]     f3;
    logic [4:0]     vd;
    logic           is_vec;
    logic           is_mv;
    int             total;
    vdec_pkg::uop_t u;
    w      = tbl_inst[e];
    f6     = w[31:26];
    vs2    = w[24:20];
    f1     = w[19:15];
    f3     = w[14:12];
    vd     = w[11:7];
    is_vec = w[6:0] == vdec_pkg::OPC_VEC;
    is_mv  = 1'b0;
    total  = 0;
    if (is_vec && (f6 == vdec_pkg::F6_VADD || f6 == vdec_pkg::F6_VSUB) &&
        (f3 == vdec_pkg::F3_OPIVV || f3 == vdec_pkg::F3_OPIVX || f3 == vdec_pkg::F3_OPIVI)) begin
      total = 1 << tbl_lmul[e];
    end else if (is_vec && f6 == vdec_pkg::F6_VMVNR && f3 == vdec_pkg::F3_OPIVI && w[25] &&
                 (f1 == 5'd0 || f1 == 5'd1 || f1 == 5'd3 || f1 == 5'd7)) begin
      is_mv = 1'b1;
      total = int'(f1) + 1;
    end
    // table count is the independent expectation
    check_value($sformatf("uop count of entry %0d", e), 64'(total), 64'(tbl_count[e]));
    for (int i = 0; i < total; i++) begin
      u.uop_index = 3'(i);
      u.last      = i == total - 1;
      u.vd        = vd + 5'(i);
      if (is_mv) begin
        u.funct6   = vdec_pkg::F6_VMVVV;
        u.funct3   = vdec_pkg::F3_OPIVV;
        u.vs2      = 5'd0;
        u.vs1      = vs2 + 5'(i);
        u.rs1_data = 32'd0;
      end else begin
        u.funct6   = f6;
        u.funct3   = f3;
        u.vs2      = vs2 + 5'(i);
        u.vs1      = (f3 == vdec_pkg::F3_OPIVV) ? f1 + 5'(i) : f1;
        u.rs1_data = (f3 == vdec_pkg::F3_OPIVX) ? tbl_rs1[e] :
                     (f3 == vdec_pkg::F3_OPIVI) ? {{27{f1[4]}}, f1} : 32'd0;
      end
      exp_q.push_back(u);
    end
  endtask

  // push each entry as soon as the command queue has room
  task automatic drive_instructions();
    logic sent;
    for (int e = 0; e < NUM_ENTRIES; e++) begin
      sent = 1'b0;
      while (!sent) begin
        @(posedge clk);
        #1;
        if (cq_full) begin
          saw_full  = 1'b1;
          inst_push = 1'b0;
        end else begin
          inst_push = 1'b1;
          inst_data = {tbl_inst[e], tbl_rs1[e], tbl_lmul[e], 3'b000};
          expand_entry(e);
          sent = 1'b1;
        end
      end
    end
    @(posedge clk);
    #1;
    inst_push = 1'b0;
    all_sent  = 1'b1;
  endtask

  // consumer with random stalls, one lfsr bit per cycle
  task automatic drain_uops();
    logic take;
    // consumer idles until every instruction is queued, so both queues back up
    wait (all_sent);
    while (received < total_uops) begin
      @(posedge clk);
      #1;
      if (cq_full) begin
        saw_full = 1'b1;
      end
      take       = lfsr_state[0];
      lfsr_state = lfsr_step(lfsr_state);
      if (!uop_empty && take) begin
        if (exp_q.size() == 0) begin
          $display("a uop arrived at %0t while none was expected", $time);
          $display("CHECKS FAILED");
          $fatal(1, "extra uop");
        end
        check_value($sformatf("uop_data[%0d]", received), 64'(uop_data),
                    64'(exp_q.pop_front()));
        uop_pop  = 1'b1;
        received = received + 1;
      end else begin
        uop_pop = 1'b0;
      end
    end
    @(posedge clk);
    #1;
    uop_pop = 1'b0;
  endtask

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles with %0d of %0d uops received",
               cycle_count, received, total_uops);
      $display("CHECKS FAILED");
      $fatal(1, "timeout");
    end
  end

  initial begin
    rst         = 1'b1;
    inst_push   = 1'b0;
    inst_data   = '0;
    uop_pop     = 1'b0;
    lfsr_state  = 8'd61;
    cycle_count = 0;
    received    = 0;
    saw_full    = 1'b0;
    all_sent    = 1'b0;
    total_uops  = 0;
    load_table();
    for (int e = 0; e < NUM_ENTRIES; e++) begin
      total_uops = total_uops + tbl_count[e];
    end
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    // both queues empty out of reset
    check_value("uop_empty", 64'(uop_empty), 64'd1);
    check_value("cq_full", 64'(cq_full), 64'd0);
    fork
      drive_instructions();
      drain_uops();
    join
    // nothing extra may trail the last uop
    repeat (10) @(posedge clk);
    #1;
    check_value("uop_empty", 64'(uop_empty), 64'd1);
    check_value("cq_full seen high", 64'(saw_full), 64'd1);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

//--- tb_clkgen.sv
`timescale 1ns/1ps

// free-running testbench clock
module tb_clkgen #(
  parameter real PERIOD_NS = 8.0
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2.0) clk = ~clk;
    end
  end

endmodule

//--- vdec_top.sv
`timescale 1ns/1ps
`include "vdec_params.svh"

module vdec_top (
  input  logic                clk,
  input  logic                rst,
  input  logic                inst_push,
  input  vdec_pkg::inst_pkg_t inst_data,
  input  logic                uop_pop,
  output logic                cq_full,
  output vdec_pkg::uop_t      uop_data,
  output logic                uop_empty
);

  vdec_pkg::inst_pkg_t inst_pkg0;
  vdec_pkg::inst_pkg_t inst_pkg1;
  logic                cq_empty;
  logic                cq_1left_to_empty;
  logic                pop0;
  logic                pop1;
  logic                push0;
  logic                push1;
  logic                push2;
  logic                push3;
  vdec_pkg::uop_t      data0;
  vdec_pkg::uop_t      data1;
  vdec_pkg::uop_t      data2;
  vdec_pkg::uop_t      data3;
  logic                uq_full;
  logic                uq_1left_to_full;
  logic                uq_2left_to_full;
  logic                uq_3left_to_full;

  // command queue, one push, two heads for the decoder
  vdec_mport_fifo #(
    .WIDTH($bits(vdec_pkg::inst_pkg_t)), .DEPTH(`CQ_DEPTH), .PUSH_PORTS(1), .POP_PORTS(2)
  ) u_cmd_queue (
    .clk(clk), .rst(rst), .push(inst_push), .push_data(inst_data),
    .pop({pop1, pop0}), .pop_data({inst_pkg1, inst_pkg0}),
    .fifo_full(cq_full), .fifo_1left_to_full(), .fifo_2left_to_full(),
    .fifo_3left_to_full(), .fifo_empty(cq_empty), .fifo_1left_to_empty(cq_1left_to_empty)
  );

  vdec_decode u_decode (
    .clk(clk), .rst(rst), .inst_pkg0(inst_pkg0), .inst_pkg1(inst_pkg1),
    .fifo_empty_cq(cq_empty), .fifo_1left_to_empty_cq(cq_1left_to_empty),
    .fifo_full(uq_full), .fifo_1left_to_full(uq_1left_to_full),
    .fifo_2left_to_full(uq_2left_to_full), .fifo_3left_to_full(uq_3left_to_full),
    .pop0(pop0), .pop1(pop1),
    .push0(push0), .data0(data0), .push1(push1), .data1(data1),
    .push2(push2), .data2(data2), .push3(push3), .data3(data3)
  );

  // uop queue, four packed pushes, one consumer
  vdec_mport_fifo #(
    .WIDTH($bits(vdec_pkg::uop_t)), .DEPTH(`UQ_DEPTH), .PUSH_PORTS(4), .POP_PORTS(1)
  ) u_uop_queue (
    .clk(clk), .rst(rst), .push({push3, push2, push1, push0}),
    .push_data({data3, data2, data1, data0}), .pop(uop_pop), .pop_data(uop_data),
    .fifo_full(uq_full), .fifo_1left_to_full(uq_1left_to_full),
    .fifo_2left_to_full(uq_2left_to_full), .fifo_3left_to_full(uq_3left_to_full),
    .fifo_empty(uop_empty), .fifo_1left_to_empty()
  );

endmodule

//--- vdec_decode.sv
`timescale 1ns/1ps
`include "vdec_params.svh"

module vdec_decode (
  input  logic                clk,
  input  logic                rst,
  input  vdec_pkg::inst_pkg_t inst_pkg0,
  input  vdec_pkg::inst_pkg_t inst_pkg1,
  input  logic                fifo_empty_cq,
  input  logic                fifo_1left_to_empty_cq,
  input  logic                fifo_full,
  input  logic                fifo_1left_to_full,
  input  logic                fifo_2left_to_full,
  input  logic                fifo_3left_to_full,
  output logic                pop0,
  output logic                pop1,
  output logic                push0,
  output vdec_pkg::uop_t      data0,
  output logic                push1,
  output vdec_pkg::uop_t      data1,
  output logic                push2,
  output vdec_pkg::uop_t      data2,
  output logic                push3,
  output vdec_pkg::uop_t      data3
);

  logic                              pkg0_valid;
  logic                              pkg1_valid;
  logic [`NUM_DE_UOP-1:0]            unit0_uop_valid;
  vdec_pkg::uop_t [`NUM_DE_UOP-1:0]  unit0_uops;
  logic [3:0]                        unit0_uop_total;
  logic [`NUM_DE_UOP-1:0]            unit1_uop_valid;
  vdec_pkg::uop_t [`NUM_DE_UOP-1:0]  unit1_uops;
  logic [`UOP_INDEX_WIDTH-1:0]       uop_index_remain;

  // head entries valid from command queue occupancy
  assign pkg0_valid = !fifo_empty_cq;
  assign pkg1_valid = !(fifo_empty_cq || fifo_1left_to_empty_cq);

  // unit 0 resumes the head instruction
  vdec_decode_unit u_decode_unit0 (
    .inst_valid      (pkg0_valid),
    .inst_pkg        (inst_pkg0),
    .uop_index_start (uop_index_remain),
    .uop_valid       (unit0_uop_valid),
    .uops            (unit0_uops),
    .uop_total       (unit0_uop_total)
  );

  // unit 1 always starts fresh
  vdec_decode_unit u_decode_unit1 (
    .inst_valid      (pkg1_valid),
    .inst_pkg        (inst_pkg1),
    .uop_index_start (`UOP_INDEX_WIDTH'(0)),
    .uop_valid       (unit1_uop_valid),
    .uops            (unit1_uops),
    .uop_total       ()
  );

  vdec_decode_ctrl u_decode_ctrl (
    .clk(clk), .rst(rst),
    .pkg0_valid(pkg0_valid), .unit0_uop_valid(unit0_uop_valid),
    .unit0_uops(unit0_uops), .unit0_uop_total(unit0_uop_total),
    .pkg1_valid(pkg1_valid), .unit1_uop_valid(unit1_uop_valid), .unit1_uops(unit1_uops),
    .fifo_full(fifo_full), .fifo_1left_to_full(fifo_1left_to_full),
    .fifo_2left_to_full(fifo_2left_to_full), .fifo_3left_to_full(fifo_3left_to_full),
    .uop_index_remain(uop_index_remain), .pop0(pop0), .pop1(pop1),
    .push0(push0), .data0(data0), .push1(push1), .data1(data1),
    .push2(push2), .data2(data2), .push3(push3), .data3(data3)
  );

endmodule

//--- vdec_decode_ctrl.sv
`timescale 1ns/1ps
`include "vdec_params.svh"

module vdec_decode_ctrl (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 pkg0_valid,
  input  logic [`NUM_DE_UOP-1:0]               unit0_uop_valid,
  input  vdec_pkg::uop_t [`NUM_DE_UOP-1:0]     unit0_uops,
  input  logic [3:0]                           unit0_uop_total,
  input  logic                                 pkg1_valid,
  input  logic [`NUM_DE_UOP-1:0]               unit1_uop_valid,
  input  vdec_pkg::uop_t [`NUM_DE_UOP-1:0]     unit1_uops,
  input  logic                                 fifo_full,
  input  logic                                 fifo_1left_to_full,
  input  logic                                 fifo_2left_to_full,
  input  logic                                 fifo_3left_to_full,
  output logic [`UOP_INDEX_WIDTH-1:0]          uop_index_remain,
  output logic                                 pop0,
  output logic                                 pop1,
  output logic                                 push0,
  output vdec_pkg::uop_t                       data0,
  output logic                                 push1,
  output vdec_pkg::uop_t                       data1,
  output logic                                 push2,
  output vdec_pkg::uop_t                       data2,
  output logic                                 push3,
  output vdec_pkg::uop_t                       data3
);

  logic [2:0]                          free_slots;
  logic [2:0]                          n0;
  logic [2:0]                          n1;
  logic [2:0]                          w0;
  logic [2:0]                          w1;
  logic                                done0;
  logic                                done1;
  logic [`NUM_DE_UOP-1:0]              push_vec;
  vdec_pkg::uop_t [`NUM_DE_UOP-1:0]    data_vec;

  // free slots in the uop queue, capped at 4
  assign free_slots = fifo_full ? 3'd0 : fifo_1left_to_full ? 3'd1 :
                      fifo_2left_to_full ? 3'd2 : fifo_3left_to_full ? 3'd3 : 3'd4;

  always_comb begin
    n0 = '0;
    n1 = '0;
    for (int k = 0; k < `NUM_DE_UOP; k++) begin
      n0 = n0 + 3'(unit0_uop_valid[k]);
      n1 = n1 + 3'(unit1_uop_valid[k]);
    end
  end

  // unit 0 first, unit 1 only behind a finished instruction 0
  always_comb begin
    w0    = (n0 < free_slots) ? n0 : free_slots;
    done0 = pkg0_valid && (unit0_uop_total == {1'b0, uop_index_remain} + 4'(w0));
    w1    = 3'd0;
    if (done0 && pkg1_valid) begin
      w1 = (n1 < free_slots - w0) ? n1 : free_slots - w0;
    end
    // inst 1 done when it has no uops or its last one goes out
    done1 = 1'b0;
    if (done0 && pkg1_valid) begin
      if (w1 == 3'd0) begin
        done1 = n1 == 3'd0;
      end else begin
        done1 = unit1_uops[2'(w1 - 3'd1)].last;
      end
    end
  end

  // pack pushes from port 0
  always_comb begin
    for (int j = 0; j < `NUM_DE_UOP; j++) begin
      if (3'(j) < w0) begin
        push_vec[j] = 1'b1;
        data_vec[j] = unit0_uops[j];
      end else if (3'(j) < w0 + w1) begin
        push_vec[j] = 1'b1;
        data_vec[j] = unit1_uops[2'(3'(j) - w0)];
      end else begin
        push_vec[j] = 1'b0;
        data_vec[j] = unit0_uops[j];
      end
    end
  end

  // split progress of the head instruction
  always_ff @(posedge clk) begin
    if (rst) begin
      uop_index_remain <= '0;
    end else if (done1) begin
      uop_index_remain <= '0;
    end else if (done0) begin
      // inst 1 becomes head, partly written
      uop_index_remain <= `UOP_INDEX_WIDTH'(w1);
    end else begin
      uop_index_remain <= uop_index_remain + `UOP_INDEX_WIDTH'(w0);
    end
  end

  assign pop0  = done0;
  assign pop1  = done1;
  assign push0 = push_vec[0];
  assign push1 = push_vec[1];
  assign push2 = push_vec[2];
  assign push3 = push_vec[3];
  assign data0 = data_vec[0];
  assign data1 = data_vec[1];
  assign data2 = data_vec[2];
  assign data3 = data_vec[3];

  // a resumed head never starts past the end of its own group
  a_remain_in_group: assert property (@(posedge clk) disable iff (rst)
    (pkg0_valid && unit0_uop_total != 4'd0) |->
      ({1'b0, uop_index_remain} < unit0_uop_total));

endmodule

//--- vdec_decode_unit.sv
`timescale 1ns/1ps
`include "vdec_params.svh"

module vdec_decode_unit (
  input  logic                                  inst_valid,
  input  vdec_pkg::inst_pkg_t                   inst_pkg,
  input  logic [`UOP_INDEX_WIDTH-1:0]           uop_index_start,
  output logic [`NUM_DE_UOP-1:0]                uop_valid,
  output vdec_pkg::uop_t [`NUM_DE_UOP-1:0]      uops,
  output logic [3:0]                            uop_total
);

  vdec_pkg::vinst_u inst;
  logic             is_vec;
  logic             is_arith;
  logic             is_vmvnr;
  logic [3:0]       lmul_total;
  logic [3:0]       nr_total;
  logic [31:0]      imm_sext;

  assign inst   = inst_pkg.inst;
  assign is_vec = inst.vreg.opcode == vdec_pkg::OPC_VEC;

  // vadd/vsub in OPIVV, OPIVX, OPIVI
  assign is_arith = is_vec &&
    (inst.vreg.funct6 == vdec_pkg::F6_VADD || inst.vreg.funct6 == vdec_pkg::F6_VSUB) &&
    (inst.vreg.funct3 inside {vdec_pkg::F3_OPIVV, vdec_pkg::F3_OPIVX, vdec_pkg::F3_OPIVI});

  // whole register move, nr-1 sits in imm5
  assign is_vmvnr = is_vec && inst.imm.funct6 == vdec_pkg::F6_VMVNR &&
    inst.imm.funct3 == vdec_pkg::F3_OPIVI && inst.imm.vm &&
    (inst.imm.imm5 inside {5'd0, 5'd1, 5'd3, 5'd7});

  assign lmul_total = 4'd1 << inst_pkg.lmul;
  assign nr_total   = {1'b0, inst.imm.imm5[2:0]} + 4'd1;
  assign imm_sext   = {{27{inst.imm.imm5[4]}}, inst.imm.imm5};

  // illegal encodings make no uops
  always_comb begin
    if (!inst_valid) begin
      uop_total = 4'd0;
    end else if (is_arith) begin
      uop_total = lmul_total;
    end else if (is_vmvnr) begin
      uop_total = nr_total;
    end else begin
      uop_total = 4'd0;
    end
  end

  always_comb begin
    logic [3:0] idx;
    for (int k = 0; k < `NUM_DE_UOP; k++) begin
      // index of this slot in the register group
      idx                = {1'b0, uop_index_start} + 4'(k);
      uop_valid[k]       = idx < uop_total;
      uops[k].uop_index  = idx[`UOP_INDEX_WIDTH-1:0];
      uops[k].last       = idx == uop_total - 4'd1;
      uops[k].vd         = inst.vreg.vd + 5'(idx);
      if (is_vmvnr) begin
        // becomes vmv.v.v vd+i, vs2+i
        uops[k].funct6   = vdec_pkg::F6_VMVVV;
        uops[k].funct3   = vdec_pkg::F3_OPIVV;
        uops[k].vs2      = 5'd0;
        uops[k].vs1      = inst.vreg.vs2 + 5'(idx);
        uops[k].rs1_data = 32'd0;
      end else begin
        uops[k].funct6   = inst.vreg.funct6;
        uops[k].funct3   = inst.vreg.funct3;
        uops[k].vs2      = inst.vreg.vs2 + 5'(idx);
        // scalar forms keep the raw field
        uops[k].vs1      = inst.vreg.vs1;
        uops[k].rs1_data = 32'd0;
        if (inst.vreg.funct3 == vdec_pkg::F3_OPIVV) begin
          uops[k].vs1 = inst.vreg.vs1 + 5'(idx);
        end else if (inst.vreg.funct3 == vdec_pkg::F3_OPIVX) begin
          uops[k].rs1_data = inst_pkg.rs1_data;
        end else begin
          uops[k].rs1_data = imm_sext;
        end
      end
    end
  end

endmodule

//--- vdec_mport_fifo.sv
`timescale 1ns/1ps

// multi-port FWFT fifo, DEPTH must be a power of two
module vdec_mport_fifo #(
  parameter int WIDTH      = 32,
  parameter int DEPTH      = 8,
  parameter int PUSH_PORTS = 1,
  parameter int POP_PORTS  = 1
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic [PUSH_PORTS-1:0]               push,
  input  logic [PUSH_PORTS-1:0][WIDTH-1:0]    push_data,
  input  logic [POP_PORTS-1:0]                pop,
  output logic [POP_PORTS-1:0][WIDTH-1:0]     pop_data,
  output logic                                fifo_full,
  output logic                                fifo_1left_to_full,
  output logic                                fifo_2left_to_full,
  output logic                                fifo_3left_to_full,
  output logic                                fifo_empty,
  output logic                                fifo_1left_to_empty
);

  localparam int AW = $clog2(DEPTH);
  localparam int CW = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic [CW-1:0]    cnt;
  logic [CW-1:0]    npush;
  logic [CW-1:0]    npop;

  // pushes and pops are packed from port 0, so a count is enough
  always_comb begin
    npush = '0;
    npop  = '0;
    for (int i = 0; i < PUSH_PORTS; i++) begin
      npush = npush + CW'(push[i]);
    end
    for (int i = 0; i < POP_PORTS; i++) begin
      npop = npop + CW'(pop[i]);
    end
  end

  // payload storage
  always_ff @(posedge clk) begin
    for (int i = 0; i < PUSH_PORTS; i++) begin
      if (push[i]) begin
        mem[wr_ptr + AW'(i)] <= push_data[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end else begin
      wr_ptr <= wr_ptr + AW'(npush);
      rd_ptr <= rd_ptr + AW'(npop);
      cnt    <= cnt + npush - npop;
    end
  end

  // head entries fall through
  always_comb begin
    for (int i = 0; i < POP_PORTS; i++) begin
      pop_data[i] = mem[rd_ptr + AW'(i)];
    end
  end

  assign fifo_full           = cnt == CW'(DEPTH);
  assign fifo_1left_to_full  = cnt == CW'(DEPTH - 1);
  assign fifo_2left_to_full  = cnt == CW'(DEPTH - 2);
  assign fifo_3left_to_full  = cnt == CW'(DEPTH - 3);
  assign fifo_empty          = cnt == '0;
  assign fifo_1left_to_empty = cnt == CW'(1);

  // free space is judged before this cycle's pops
  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    int'(npush) <= DEPTH - int'(cnt));
  a_no_underflow: assert property (@(posedge clk) disable iff (rst)
    npop <= cnt);

endmodule

//--- vdec_pkg.sv
`include "vdec_params.svh"

package vdec_pkg;

  // vector register view of the instruction word
  typedef struct packed {
    logic [5:0] funct6;
    logic       vm;
    logic [4:0] vs2;
    logic [4:0] vs1;
    logic [2:0] funct3;
    logic [4:0] vd;
    logic [6:0] opcode;
  } vinst_vreg_t;

  // immediate view, imm5 is simm5 for OPIVI or nr-1 for vmv<nr>r.v
  typedef struct packed {
    logic [5:0] funct6;
    logic       vm;
    logic [4:0] vs2;
    logic [4:0] imm5;
    logic [2:0] funct3;
    logic [4:0] vd;
    logic [6:0] opcode;
  } vinst_imm_t;

  typedef union packed {
    vinst_vreg_t vreg;
    vinst_imm_t  imm;
  } vinst_u;

  // command queue entry, 69 bits
  typedef struct packed {
    vinst_u      inst;
    logic [31:0] rs1_data;
    // lmul code 0..3 -> LMUL 1, 2, 4, 8
    logic [1:0]  lmul;
    logic [2:0]  spare;
  } inst_pkg_t;

  // uop queue entry
  typedef struct packed {
    logic [5:0]                  funct6;
    logic [2:0]                  funct3;
    logic [4:0]                  vd;
    logic [4:0]                  vs2;
    logic [4:0]                  vs1;
    logic [31:0]                 rs1_data;
    logic [`UOP_INDEX_WIDTH-1:0] uop_index;
    logic                        last;
  } uop_t;

  localparam logic [6:0] OPC_VEC   = 7'b1010111;
  localparam logic [2:0] F3_OPIVV  = 3'b000;
  localparam logic [2:0] F3_OPIVI  = 3'b011;
  localparam logic [2:0] F3_OPIVX  = 3'b100;
  localparam logic [5:0] F6_VADD   = 6'b000000;
  localparam logic [5:0] F6_VSUB   = 6'b000010;
  localparam logic [5:0] F6_VMVNR  = 6'b100111;
  localparam logic [5:0] F6_VMVVV  = 6'b010111;

endpackage

//--- vdec_params.svh
`ifndef VDEC_PARAMS_SVH
`define VDEC_PARAMS_SVH

// uops the decoder can write into the uop queue per cycle
`define NUM_DE_UOP 4

// uop index within one instruction, up to 8 uops (LMUL 8 or vmv8r)
`define UOP_INDEX_WIDTH 3

// command queue depth, power of two
`define CQ_DEPTH 8

// uop queue depth, power of two
`define UQ_DEPTH 16

// largest uop count of one instruction
`define MAX_UOP_TOTAL 8

`endif
